// File: Makefile
# Verilator build, run and lint for the soc bus glue testbench
# any variable can be overridden, e.g. make TOP=... OBJ_DIR=...

VERILATOR  ?= verilator
TOP        ?= tb_soc_bus_core
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+include
verilog/soc_pkg.sv
verilog/soc_reset_seq.sv
verilog/soc_bus_decode.sv
verilog/soc_vblank_irq.sv
verilog/soc_mem.sv
verilog/soc_bus_core.sv
testbench/tb_soc_bus_core.sv

// File: include/soc_cfg.svh
// build-time sizes for the z80 soc bus glue
// include wherever reset length or memory and video widths are needed
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// core reset hold after the last reset source clears, in cpu_clock cycles
// must fit the 8 bit hold counter
`define SOC_RESET_HOLD 255

// byte memory behind the bus, full z80 address space
`define SOC_MEM_ADDR_BITS 16

// video memory write address, 16k window below A15
`define SOC_VIDEO_ADDR_BITS 14

`endif

// File: testbench/tb_soc_bus_core.sv
// directed testbench for the z80 soc bus glue
// runs reset hold, download, ram, video and irq tests in order, stops at first error
`timescale 1ns/100ps
`default_nettype none
`include "soc_cfg.svh"

module tb_soc_bus_core;

   import soc_pkg::*;

   localparam int clk_period = 20;
   localparam logic [31:0] rand_seed = 32'hd4b1;
   localparam int n_dl  = 16;   // download writes
   localparam int n_ram = 12;   // cpu ram writes
   localparam int n_vid = 8;    // cpu video writes
   // rough cycle budget of all tests, doubled for margin
   localparam int watchdog_cycles =
      2 * (16 + 3 * `SOC_RESET_HOLD + 150 + n_dl * 11 + n_ram * 6 + n_vid * 3 + 60);

   logic                            cpu_clock;
   logic                            cpu_reset;
   logic                            pll_locked;
   logic [7:0]                      osd_status;
   cpu_addr_t                       cpu_addr;
   byte_t                           cpu_dout;
   logic                            cpu_rd_n;
   logic                            cpu_wr_n;
   logic                            cpu_iorq_n;
   logic                            cpu_m1_n;
   logic                            dio_download;
   logic                            dio_write;
   dio_addr_t                       dio_addr;
   byte_t                           dio_data;
   logic                            video_vs;
   logic                            core_reset;
   byte_t                           cpu_din;
   logic                            irq_n;
   logic                            video_wr;
   logic [`SOC_VIDEO_ADDR_BITS-1:0] video_addr;
   byte_t                           video_data;

   logic [31:0] rng_state = rand_seed;
   byte_t       model_mem [0:65535];  // mirror of what memory should hold
   logic [15:0] dl_addrs [$];         // addresses written by the download
   logic [15:0] ram_addrs [$];

   soc_bus_core dut_i (
      .cpu_clock    (cpu_clock),
      .cpu_reset    (cpu_reset),
      .pll_locked   (pll_locked),
      .osd_status   (osd_status),
      .cpu_addr     (cpu_addr),
      .cpu_dout     (cpu_dout),
      .cpu_rd_n     (cpu_rd_n),
      .cpu_wr_n     (cpu_wr_n),
      .cpu_iorq_n   (cpu_iorq_n),
      .cpu_m1_n     (cpu_m1_n),
      .dio_download (dio_download),
      .dio_write    (dio_write),
      .dio_addr     (dio_addr),
      .dio_data     (dio_data),
      .video_vs     (video_vs),
      .core_reset   (core_reset),
      .cpu_din      (cpu_din),
      .irq_n        (irq_n),
      .video_wr     (video_wr),
      .video_addr   (video_addr),
      .video_data   (video_data)
   );

   initial begin
      cpu_clock = 1'b0;
      forever #(clk_period / 2) cpu_clock = ~cpu_clock;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else
         fail_stop($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   // one cycle, then look at outputs mid-cycle where they are settled
   task automatic step();
      @(posedge cpu_clock);
      @(negedge cpu_clock);
   endtask

   // call right after the edge that clears the last reset source
   task automatic count_hold();
      int k;
      for (k = 1; k < `SOC_RESET_HOLD; k++) begin
         step();
         check_eq("core_reset", 32'(core_reset), 32'h1);
      end
      step();
      check_eq("core_reset", 32'(core_reset), 32'h0);  // falls on edge 255
   endtask

   task automatic wait_core_release();
      int waited;
      waited = 0;
      do begin
         step();
         waited++;
      end while (core_reset && waited <= `SOC_RESET_HOLD + 4);
      assert (!core_reset) else
         fail_stop("core_reset stayed high well past the reset hold time");
   endtask

   task automatic cpu_read(input logic [15:0] a);
      @(posedge cpu_clock);
      cpu_addr <= a;
      cpu_rd_n <= 1'b0;
      @(posedge cpu_clock);           // decoder samples the strobe
      @(posedge cpu_clock);           // memory returns data
      cpu_rd_n <= 1'b1;
      @(negedge cpu_clock);
      check_eq("cpu_din", 32'(cpu_din), 32'(model_mem[a]));
   endtask

   // checks the video pulse too, A15 low must give exactly one video_wr
   task automatic cpu_write(input logic [15:0] a, input byte_t d);
      @(posedge cpu_clock);
      cpu_addr <= a;
      cpu_dout <= d;
      cpu_wr_n <= 1'b0;
      @(posedge cpu_clock);
      cpu_wr_n <= 1'b1;
      @(negedge cpu_clock);
      check_eq("video_wr", 32'(video_wr), 32'(!a[15]));
      if (!a[15]) begin
         check_eq("video_addr", 32'(video_addr), 32'(a[13:0]));
         check_eq("video_data", 32'(video_data), 32'(d));
      end
      step();
      check_eq("video_wr", 32'(video_wr), 32'h0);  // one cycle pulse
      if (a[15]) begin
         model_mem[a] = d;   // ram only, video side never reads back
      end
   endtask

   task automatic run_reset_hold();
      @(posedge cpu_clock);
      osd_status <= 8'h04;      // menu reset
      repeat (3) begin
         step();
         check_eq("core_reset", 32'(core_reset), 32'h1);
      end
      @(posedge cpu_clock);
      osd_status <= 8'h00;
      count_hold();
      // restart mid count with a short download pulse
      @(posedge cpu_clock);
      osd_status <= 8'h04;
      @(posedge cpu_clock);
      osd_status <= 8'h00;
      repeat (100) begin
         step();
         check_eq("core_reset", 32'(core_reset), 32'h1);
      end
      @(posedge cpu_clock);
      dio_download <= 1'b1;
      repeat (2) @(posedge cpu_clock);
      dio_download <= 1'b0;
      count_hold();
   endtask

   task automatic run_download();
      int i;
      logic [31:0] r;
      logic [15:0] a;
      byte_t d;
      @(posedge cpu_clock);
      dio_download <= 1'b1;
      for (i = 0; i < n_dl; i++) begin
         r = next_rand();
         a = r[15:0];
         a[15] = i[0];                   // half of the image below A15
         d = 8'(next_rand());
         @(posedge cpu_clock);
         dio_write <= 1'b1;
         dio_addr  <= {r[31:23], a};     // upper bits dropped by the decoder
         dio_data  <= d;
         cpu_addr  <= {1'b0, a[14:0]};   // cpu tries a video write meanwhile
         cpu_dout  <= ~d;
         cpu_wr_n  <= 1'b0;
         model_mem[a] = d;
         dl_addrs.push_back(a);
         @(negedge cpu_clock);
         check_eq("video_wr", 32'(video_wr), 32'h0);
         @(posedge cpu_clock);
         dio_write <= 1'b0;
         @(negedge cpu_clock);
         check_eq("video_wr", 32'(video_wr), 32'h0);
      end
      @(posedge cpu_clock);
      dio_download <= 1'b0;
      cpu_wr_n     <= 1'b1;
      @(negedge cpu_clock);
      check_eq("core_reset", 32'(core_reset), 32'h1);
      wait_core_release();
      foreach (dl_addrs[i]) begin
         cpu_read(dl_addrs[i]);
      end
   endtask

   task automatic run_ram_writes();
      int i;
      logic [15:0] a;
      for (i = 0; i < n_ram; i++) begin
         a = 16'(next_rand()) | 16'h8000;
         cpu_write(a, 8'(next_rand()));
         ram_addrs.push_back(a);
      end
      foreach (ram_addrs[i]) begin
         cpu_read(ram_addrs[i]);
      end
      // writes below A15 leave the downloaded bytes alone
      foreach (dl_addrs[i]) begin
         if (!dl_addrs[i][15]) begin
            cpu_write(dl_addrs[i], ~model_mem[dl_addrs[i]]);
            cpu_read(dl_addrs[i]);
         end
      end
   endtask

   task automatic run_video_writes();
      int i;
      for (i = 0; i < n_vid; i++) begin
         cpu_write(16'(next_rand()) & 16'h7fff, 8'(next_rand()));
      end
      cpu_write(16'(next_rand()) | 16'h8000, 8'h5a);  // no video pulse above A15
   endtask

   task automatic vs_rise_check();
      @(posedge cpu_clock);
      video_vs <= 1'b1;
      step();
      check_eq("irq_n", 32'(irq_n), 32'h1);   // still in the synchronizer
      step();
      check_eq("irq_n", 32'(irq_n), 32'h0);
   endtask

   task automatic ack_check();
      @(posedge cpu_clock);
      cpu_iorq_n <= 1'b0;
      cpu_m1_n   <= 1'b0;
      @(posedge cpu_clock);
      cpu_iorq_n <= 1'b1;
      cpu_m1_n   <= 1'b1;
      @(negedge cpu_clock);
      check_eq("irq_n", 32'(irq_n), 32'h1);
   endtask

   task automatic run_irq();
      check_eq("irq_n", 32'(irq_n), 32'h1);
      vs_rise_check();
      repeat (6) begin
         step();
         check_eq("irq_n", 32'(irq_n), 32'h0);  // held while vs stays high
      end
      ack_check();
      repeat (4) begin
         step();
         check_eq("irq_n", 32'(irq_n), 32'h1);  // no new edge yet
      end
      @(posedge cpu_clock);
      video_vs <= 1'b0;
      repeat (4) @(posedge cpu_clock);
      vs_rise_check();                           // next frame
      ack_check();
      @(posedge cpu_clock);
      video_vs <= 1'b0;
   endtask

   initial begin
      repeat (watchdog_cycles) @(posedge cpu_clock);
      fail_stop("timeout: the tests did not finish within the expected number of cycles");
   end

   initial begin
      cpu_reset    <= 1'b1;
      pll_locked   <= 1'b1;
      osd_status   <= 8'h00;
      cpu_addr     <= '0;
      cpu_dout     <= '0;
      cpu_rd_n     <= 1'b1;
      cpu_wr_n     <= 1'b1;
      cpu_iorq_n   <= 1'b1;
      cpu_m1_n     <= 1'b1;
      dio_download <= 1'b0;
      dio_write    <= 1'b0;
      dio_addr     <= '0;
      dio_data     <= '0;
      video_vs     <= 1'b0;
      repeat (15) @(posedge cpu_clock);
      @(negedge cpu_clock);
      check_eq("core_reset", 32'(core_reset), 32'h1);
      @(posedge cpu_clock);                      // 16th reset cycle
      cpu_reset <= 1'b0;
      @(negedge cpu_clock);
      check_eq("video_wr", 32'(video_wr), 32'h0);
      check_eq("irq_n", 32'(irq_n), 32'h1);
      run_reset_hold();
      run_download();
      run_ram_writes();
      run_video_writes();
      run_irq();
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/soc_bus_core.sv
// top of the z80 soc bus glue, reset, decode, memory and vblank irq
// core, video engine, pll and download helper sit outside on loose ports
`timescale 1ns/100ps
`default_nettype none
`include "soc_cfg.svh"

module soc_bus_core (
   input  wire                               cpu_clock,
   input  wire                               cpu_reset,
   input  wire                               pll_locked,
   input  wire [7:0]                         osd_status,   // from user_io
   // z80 bus
   input  wire soc_pkg::cpu_addr_t           cpu_addr,
   input  wire soc_pkg::byte_t               cpu_dout,
   input  wire                               cpu_rd_n,
   input  wire                               cpu_wr_n,
   input  wire                               cpu_iorq_n,
   input  wire                               cpu_m1_n,
   // rom download helper
   input  wire                               dio_download,
   input  wire                               dio_write,
   input  wire soc_pkg::dio_addr_t           dio_addr,
   input  wire soc_pkg::byte_t               dio_data,
   // video
   input  wire                               video_vs,
   output logic                              core_reset,   // to core RESET_n, inverted
   output soc_pkg::byte_t                    cpu_din,
   output logic                              irq_n,
   output logic                              video_wr,
   output logic [`SOC_VIDEO_ADDR_BITS-1:0]   video_addr,
   output soc_pkg::byte_t                    video_data
);

   import soc_pkg::*;

   // decoder to memory
   logic                          mem_wr;
   logic                          mem_rd;
   logic [`SOC_MEM_ADDR_BITS-1:0] mem_addr;
   byte_t                         mem_wdata;

   soc_reset_seq reset_seq_i (
      .cpu_clock    (cpu_clock),
      .cpu_reset    (cpu_reset),
      .pll_locked   (pll_locked),
      .osd_status   (osd_status),
      .dio_download (dio_download),
      .core_reset   (core_reset)
   );

   soc_bus_decode bus_decode_i (
      .cpu_clock    (cpu_clock),
      .cpu_reset    (cpu_reset),
      .core_reset   (core_reset),
      .cpu_addr     (cpu_addr),
      .cpu_dout     (cpu_dout),
      .cpu_rd_n     (cpu_rd_n),
      .cpu_wr_n     (cpu_wr_n),
      .dio_download (dio_download),
      .dio_write    (dio_write),
      .dio_addr     (dio_addr),
      .dio_data     (dio_data),
      .video_wr     (video_wr),
      .video_addr   (video_addr),
      .video_data   (video_data),
      .mem_wr       (mem_wr),
      .mem_rd       (mem_rd),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata)
   );

   // read path, two edges from rd_n to cpu_din
   soc_mem mem_i (
      .cpu_clock (cpu_clock),
      .mem_wr    (mem_wr),
      .mem_rd    (mem_rd),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .cpu_din   (cpu_din)
   );

   soc_vblank_irq vblank_irq_i (
      .cpu_clock  (cpu_clock),
      .core_reset (core_reset),
      .video_vs   (video_vs),
      .cpu_iorq_n (cpu_iorq_n),
      .cpu_m1_n   (cpu_m1_n),
      .irq_n      (irq_n)
   );

endmodule

`default_nettype wire

// File: verilog/soc_bus_decode.sv
// z80 bus decode, steers cpu strobes to video or memory by A15
// download helper owns the memory port while dio_download is high
`timescale 1ns/100ps
`default_nettype none
`include "soc_cfg.svh"

module soc_bus_decode (
   input  wire                                 cpu_clock,
   input  wire                                 cpu_reset,
   input  wire                                 core_reset,  // core held, cpu bus invalid
   input  wire soc_pkg::cpu_addr_t             cpu_addr,
   input  wire soc_pkg::byte_t                 cpu_dout,
   input  wire                                 cpu_rd_n,
   input  wire                                 cpu_wr_n,
   input  wire                                 dio_download,
   input  wire                                 dio_write,
   input  wire soc_pkg::dio_addr_t             dio_addr,
   input  wire soc_pkg::byte_t                 dio_data,
   output logic                                video_wr,
   output logic [`SOC_VIDEO_ADDR_BITS-1:0]     video_addr,
   output soc_pkg::byte_t                      video_data,
   output logic                                mem_wr,
   output logic                                mem_rd,
   output logic [`SOC_MEM_ADDR_BITS-1:0]       mem_addr,
   output soc_pkg::byte_t                      mem_wdata
);

   import soc_pkg::*;

   logic                          cpu_ok;      // cpu may issue requests
   logic                          video_wr_d;
   logic                          mem_wr_d;
   logic                          mem_rd_d;
   logic [`SOC_MEM_ADDR_BITS-1:0] mem_addr_d;
   byte_t                         mem_wdata_d;

   // no cpu traffic while the core is held or rom loads
   assign cpu_ok = ~core_reset & ~dio_download;

   // A15 low is video memory, written only, never read back
   assign video_wr_d = cpu_ok & ~cpu_wr_n & ~cpu_addr[15];

   // ram writes from cpu above A15, or every download write
   assign mem_wr_d = dio_download ? dio_write : (cpu_ok & ~cpu_wr_n & cpu_addr[15]);

   // reads always hit memory, write takes priority
   assign mem_rd_d = cpu_ok & ~cpu_rd_n & ~mem_wr_d;

   // memory port mux, download truncated to memory size
   assign mem_addr_d  = dio_download ? dio_addr[`SOC_MEM_ADDR_BITS-1:0]
                                     : cpu_addr[`SOC_MEM_ADDR_BITS-1:0];
   assign mem_wdata_d = dio_download ? dio_data : cpu_dout;

   // strobes, cleared in reset
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         video_wr <= 1'b0;
         mem_wr   <= 1'b0;
         mem_rd   <= 1'b0;
      end else begin
         video_wr <= video_wr_d;  // repeats while wr_n held, same data
         mem_wr   <= mem_wr_d;
         mem_rd   <= mem_rd_d;
      end
   end

   // payload follows the bus every cycle
   always_ff @(posedge cpu_clock) begin
      video_addr <= cpu_addr[`SOC_VIDEO_ADDR_BITS-1:0];
      video_data <= cpu_dout;
      mem_addr   <= mem_addr_d;
      mem_wdata  <= mem_wdata_d;
   end

   // rom image must never leak into video memory
   a_no_video_in_dl : assert property (@(posedge cpu_clock) disable iff (cpu_reset)
      dio_download |=> !video_wr);

   // memory sees one request kind per cycle
   a_wr_rd_onehot : assert property (@(posedge cpu_clock) disable iff (cpu_reset)
      !(mem_wr && mem_rd));

endmodule

`default_nettype wire

// File: verilog/soc_mem.sv
// behavioral byte memory in place of the sdram controller
// registered write, registered read into cpu_din
`timescale 1ns/100ps
`default_nettype none
`include "soc_cfg.svh"

module soc_mem (
   input  wire                               cpu_clock,
   input  wire                               mem_wr,     // decoded write
   input  wire                               mem_rd,     // decoded read
   input  wire [`SOC_MEM_ADDR_BITS-1:0]      mem_addr,
   input  wire soc_pkg::byte_t               mem_wdata,
   output soc_pkg::byte_t                    cpu_din     // read data to the core
);

   import soc_pkg::*;

   localparam int mem_depth = 2 ** `SOC_MEM_ADDR_BITS;

   // lower half holds the rom image after a download
   // upper half is system ram
   byte_t mem_array [mem_depth];

   // write lands one edge after the decoded request
   always_ff @(posedge cpu_clock) begin
      if (mem_wr) begin
         mem_array[mem_addr] <= mem_wdata;
      end
   end

   // read data on the edge after the decoded read
   // holds between reads, like the sdram output latch
   always_ff @(posedge cpu_clock) begin
      if (mem_rd) begin
         cpu_din <= mem_array[mem_addr];  // old data on same-address write
      end
   end

endmodule

`default_nettype wire

// File: verilog/soc_pkg.sv
// shared data types for the z80 soc bus glue
// import where bytes or cpu and download addresses are carried
`default_nettype none

package soc_pkg;

   // one data byte
   // cpu data bus, download data and video data all use it
   typedef logic [7:0] byte_t;

   // z80 address bus, A15 selects ram against video
   typedef logic [15:0] cpu_addr_t;

   // rom download helper address
   // wider than memory, decoder keeps the low bits only
   typedef logic [24:0] dio_addr_t;

endpackage

`default_nettype wire

// File: verilog/soc_reset_seq.sv
// reset sequencer for the z80 core
// keeps core_reset high for a fixed hold after every reset source drops
`timescale 1ns/100ps
`default_nettype none
`include "soc_cfg.svh"

module soc_reset_seq (
   input  wire       cpu_clock,
   input  wire       cpu_reset,     // board reset
   input  wire       pll_locked,    // low while clocks are unstable
   input  wire [7:0] osd_status,    // bit 0 power-up, bit 2 menu reset
   input  wire       dio_download,  // rom download in progress
   output logic      core_reset
);

   localparam logic [7:0] hold_max = 8'(`SOC_RESET_HOLD);

   logic [7:0] hold_cnt;  // cycles since last source cleared
   logic       reset_src; // any source still active

   // menu reset and download restart the hold like a power-up
   assign reset_src = ~pll_locked | osd_status[0] | osd_status[2] | dio_download;

   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         hold_cnt <= '0;
      end else if (reset_src) begin
         hold_cnt <= '0;                    // restart on every source
      end else if (hold_cnt != hold_max) begin
         hold_cnt <= hold_cnt + 8'd1;       // saturates at hold_max
      end
   end

   // gives sdram time to init once clocks are stable or a download ends
   assign core_reset = (hold_cnt < hold_max);

   // a live reset source always holds the core on the next cycle
   a_src_holds : assert property (@(posedge cpu_clock) disable iff (cpu_reset)
      reset_src |=> core_reset);

endmodule

`default_nettype wire

// File: verilog/soc_vblank_irq.sv
// vertical blank interrupt for the z80
// one irq per frame on vsync rise and held until the cpu acknowledges it
`timescale 1ns/100ps
`default_nettype none

module soc_vblank_irq (
   input  wire  cpu_clock,
   input  wire  core_reset,  // keeps irq_n released
   input  wire  video_vs,    // from the pixel clock domain
   input  wire  cpu_iorq_n,
   input  wire  cpu_m1_n,
   output logic irq_n         // active low to the core
);

   logic vs_meta;   // first sync stage
   logic vs_sync;   // second sync stage
   logic vs_rise;
   logic irq_ack;

   // two flop vsync synchronizer
   always_ff @(posedge cpu_clock) begin
      vs_meta <= video_vs;
      vs_sync <= vs_meta;
   end

   assign vs_rise = vs_meta & ~vs_sync;    // edge between the two stages
   assign irq_ack = ~cpu_iorq_n & ~cpu_m1_n; // im1 acknowledge cycle

   always_ff @(posedge cpu_clock) begin
      if (core_reset) begin
         irq_n <= 1'b1;
      end else if (irq_ack) begin
         irq_n <= 1'b1;   // ack beats a new edge in the same cycle
      end else if (vs_rise) begin
         irq_n <= 1'b0;
      end
   end

   // acknowledge always releases the line on the next edge
   a_ack_release : assert property (@(posedge cpu_clock) disable iff (core_reset)
      irq_ack |=> irq_n);

endmodule

`default_nettype wire
